/* logic/deconv_defs.svh */
`ifndef DECONV_DEFS_SVH
`define DECONV_DEFS_SVH

// Data widths
`define PIX_WIDTH    16
`define ACC_WIDTH    32

// Kernel and row geometry
`define KERNEL_SIZE  3
`define STRIDE       1
`define ROW_LEN      4
`define OUT_LEN      6

// Buffering and credits
`define FEAT_DEPTH   4
`define OUT_DEPTH    8
`define OUT_CREDITS  4

`endif

/* logic/deconv_pkg.sv */
package deconv_pkg;

`include "deconv_defs.svh"

    // Feature and weight pixel
    typedef logic signed [`PIX_WIDTH-1:0] pix_t;

    // Partial or final sum
    typedef logic signed [`ACC_WIDTH-1:0] acc_t;

    // One kernel, tap 0 first
    typedef pix_t kernel_t [`KERNEL_SIZE];

    // Products of one pixel with every tap
    typedef acc_t prod_t [`KERNEL_SIZE];

endpackage

/* logic/credit_fifo.sv */
`timescale 1ns/1ps

module credit_fifo
    import deconv_pkg::*;
#(
    parameter type T     = pix_t,
    parameter int  DEPTH = 4
)(
    input  logic                   i_clk,
    input  logic                   i_rst_n,
    input  logic                   i_push,
    input  T                       i_data,
    input  logic                   i_pop,
    output T                       o_data,
    output logic                   o_empty,
    output logic [$clog2(DEPTH):0] o_count,
    output logic                   o_credit
);

    localparam int AW = (DEPTH > 1) ? $clog2(DEPTH) : 1;

    T              mem [DEPTH];
    logic [AW-1:0] wr_ptr;
    logic [AW-1:0] rd_ptr;

    function automatic logic [AW-1:0] ptr_next(input logic [AW-1:0] ptr);
        if (ptr == AW'(DEPTH - 1))
        begin
            return '0;
        end
        return ptr + 1'b1;
    endfunction

    always_ff @(posedge i_clk)
    begin
        if (i_push)
        begin
            mem[wr_ptr] <= i_data;
        end
    end

    always_ff @(posedge i_clk or negedge i_rst_n)
    begin
        if (!i_rst_n)
        begin
            wr_ptr   <= '0;
            rd_ptr   <= '0;
            o_count  <= '0;
            o_credit <= 1'b0;
        end
        else
        begin
            if (i_push)
            begin
                wr_ptr <= ptr_next(wr_ptr);
            end
            if (i_pop)
            begin
                rd_ptr <= ptr_next(rd_ptr);
            end
            case ({i_push, i_pop})
                2'b10:   o_count <= o_count + 1'b1;
                2'b01:   o_count <= o_count - 1'b1;
                default: o_count <= o_count;
            endcase
            // One slot freed per pop
            o_credit <= i_pop;
        end
    end

    // Head word, valid whenever not empty
    assign o_data  = mem[rd_ptr];
    assign o_empty = (o_count == '0);

    // Sender must hold a credit, reader must see data
    a_no_overflow: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        i_push |-> (o_count != DEPTH));
    a_no_underflow: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        i_pop |-> !o_empty);

endmodule

/* logic/weight_loader.sv */
`timescale 1ns/1ps

`include "deconv_defs.svh"

module weight_loader
    import deconv_pkg::*;
(
    input  logic    i_clk,
    input  logic    i_rst_n,
    input  logic    i_w_valid,
    input  pix_t    i_w_data,
    input  logic    i_w_reload,
    output logic    o_w_credit,
    output kernel_t o_weights,
    output logic    o_loaded
);

    localparam int TW = $clog2(`KERNEL_SIZE + 1);

    logic [TW-1:0] tap_idx;
    logic [TW-1:0] ret_cnt;

    // Taps stay put across rows until overwritten
    always_ff @(posedge i_clk)
    begin
        if (i_w_valid)
        begin
            o_weights[tap_idx] <= i_w_data;
        end
    end

    always_ff @(posedge i_clk or negedge i_rst_n)
    begin
        if (!i_rst_n)
        begin
            tap_idx  <= '0;
            ret_cnt  <= '0;
            o_loaded <= 1'b0;
        end
        else if (i_w_reload)
        begin
            tap_idx  <= '0;
            ret_cnt  <= TW'(`KERNEL_SIZE);
            o_loaded <= 1'b0;
        end
        else
        begin
            if (ret_cnt != '0)
            begin
                ret_cnt <= ret_cnt - 1'b1;
            end
            if (i_w_valid)
            begin
                if (tap_idx == TW'(`KERNEL_SIZE - 1))
                begin
                    tap_idx  <= '0;
                    o_loaded <= 1'b1;
                end
                else
                begin
                    tap_idx <= tap_idx + 1'b1;
                end
            end
        end
    end

    // One credit per cycle after reload
    assign o_w_credit = (ret_cnt != '0);

    a_no_weight_when_loaded: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        i_w_valid |-> !o_loaded);

endmodule

/* logic/column_mac.sv */
`timescale 1ns/1ps

`include "deconv_defs.svh"

module column_mac
    import deconv_pkg::*;
(
    input  logic    i_clk,
    input  logic    i_rst_n,
    input  logic    i_valid,
    input  pix_t    i_pix,
    input  kernel_t i_weights,
    output logic    o_valid,
    output prod_t   o_prod
);

    // Scatter one pixel over all taps
    always_ff @(posedge i_clk)
    begin
        if (i_valid)
        begin
            for (int k = 0; k < `KERNEL_SIZE; k++)
            begin
                o_prod[k] <= acc_t'(i_pix) * acc_t'(i_weights[k]);
            end
        end
    end

    always_ff @(posedge i_clk or negedge i_rst_n)
    begin
        if (!i_rst_n)
        begin
            o_valid <= 1'b0;
        end
        else
        begin
            o_valid <= i_valid;
        end
    end

endmodule

/* logic/overlap_add.sv */
`timescale 1ns/1ps

`include "deconv_defs.svh"

module overlap_add
    import deconv_pkg::*;
(
    input  logic  i_clk,
    input  logic  i_rst_n,
    input  logic  i_valid,
    input  prod_t i_prod,
    output logic  o_ready,
    output logic  o_push,
    output acc_t  o_sum
);

    localparam int EW = $clog2(`KERNEL_SIZE + 1);
    localparam int RW = $clog2(`ROW_LEN + 1);

    acc_t          win [`KERNEL_SIZE];
    prod_t         pend_prod;
    logic          pend_valid;
    logic          pend_last;
    logic [RW-1:0] in_cnt;
    logic [EW-1:0] emit_cnt;
    logic          accept;
    logic          last_in;

    assign o_ready = !pend_valid && (emit_cnt == '0);
    assign accept  = i_valid && o_ready;
    assign last_in = (in_cnt == RW'(`ROW_LEN - 1));

    // Window base is always the next output to leave
    assign o_push  = (emit_cnt != '0);
    assign o_sum   = win[0];

    always_ff @(posedge i_clk)
    begin
        if (accept)
        begin
            pend_prod <= i_prod;
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Row position and pending set
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge i_clk or negedge i_rst_n)
    begin
        if (!i_rst_n)
        begin
            pend_valid <= 1'b0;
            pend_last  <= 1'b0;
            in_cnt     <= '0;
        end
        else
        begin
            pend_valid <= accept;
            if (accept)
            begin
                pend_last <= last_in;
                in_cnt    <= last_in ? '0 : in_cnt + 1'b1;
            end
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Accumulate window and shift out finished sums
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge i_clk or negedge i_rst_n)
    begin
        if (!i_rst_n)
        begin
            emit_cnt <= '0;
            for (int k = 0; k < `KERNEL_SIZE; k++)
            begin
                win[k] <= '0;
            end
        end
        else if (pend_valid)
        begin
            for (int k = 0; k < `KERNEL_SIZE; k++)
            begin
                win[k] <= win[k] + pend_prod[k];
            end
            // Last input of a row flushes the whole window
            emit_cnt <= pend_last ? EW'(`KERNEL_SIZE) : EW'(`STRIDE);
        end
        else if (emit_cnt != '0)
        begin
            for (int k = 0; k < `KERNEL_SIZE - 1; k++)
            begin
                win[k] <= win[k + 1];
            end
            win[`KERNEL_SIZE - 1] <= '0;
            emit_cnt <= emit_cnt - 1'b1;
        end
    end

    a_valid_only_when_ready: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        i_valid |-> o_ready);

endmodule

/* logic/deconv_ctrl.sv */
`timescale 1ns/1ps

`include "deconv_defs.svh"

module deconv_ctrl
    import deconv_pkg::*;
(
    input  logic                        i_clk,
    input  logic                        i_rst_n,
    input  logic                        i_loaded,
    input  logic                        i_feat_empty,
    input  logic                        i_mac_ready,
    input  logic [$clog2(`OUT_DEPTH):0] i_out_count,
    input  logic                        i_out_empty,
    input  acc_t                        i_out_data,
    input  logic                        i_out_credit,
    output logic                        o_feat_pop,
    output logic                        o_out_pop,
    output logic                        o_out_valid,
    output acc_t                        o_out_data
);

    localparam int OCW = $clog2(`OUT_DEPTH) + 1;
    // Extra bit so an over-credit is visible
    localparam int CW  = $clog2(`OUT_CREDITS + 1) + 1;

    logic          in_flight;
    logic          room;
    logic [CW-1:0] credit_cnt;

    ////////////////////////////////////////////////////////////////////////////
    // Feature admission
    ////////////////////////////////////////////////////////////////////////////

    // Room for a full row tail in the output buffer
    assign room       = (i_out_count <= OCW'(`OUT_DEPTH - `KERNEL_SIZE));
    assign o_feat_pop = i_loaded && !i_feat_empty && i_mac_ready && !in_flight && room;

    always_ff @(posedge i_clk or negedge i_rst_n)
    begin
        if (!i_rst_n)
        begin
            in_flight <= 1'b0;
        end
        else
        begin
            // MAC hands over exactly one cycle after the pop
            in_flight <= o_feat_pop;
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Output drain against receiver credits
    ////////////////////////////////////////////////////////////////////////////

    assign o_out_pop = !i_out_empty && (credit_cnt != '0);

    always_ff @(posedge i_clk or negedge i_rst_n)
    begin
        if (!i_rst_n)
        begin
            credit_cnt  <= CW'(`OUT_CREDITS);
            o_out_valid <= 1'b0;
        end
        else
        begin
            case ({i_out_credit, o_out_pop})
                2'b10:   credit_cnt <= credit_cnt + 1'b1;
                2'b01:   credit_cnt <= credit_cnt - 1'b1;
                default: credit_cnt <= credit_cnt;
            endcase
            o_out_valid <= o_out_pop;
        end
    end

    always_ff @(posedge i_clk)
    begin
        if (o_out_pop)
        begin
            o_out_data <= i_out_data;
        end
    end

    a_credit_bound: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        credit_cnt <= CW'(`OUT_CREDITS));

endmodule

/* logic/deconv_top.sv */
`timescale 1ns/1ps

`include "deconv_defs.svh"

module deconv_top
    import deconv_pkg::*;
(
    input  logic i_clk,
    input  logic i_rst_n,
    input  logic i_feat_valid,
    input  pix_t i_feat_data,
    output logic o_feat_credit,
    input  logic i_w_valid,
    input  pix_t i_w_data,
    input  logic i_w_reload,
    output logic o_w_credit,
    output logic o_out_valid,
    output acc_t o_out_data,
    input  logic i_out_credit
);

    pix_t                        feat_data;
    logic                        feat_empty;
    logic                        feat_pop;
    kernel_t                     weights;
    logic                        loaded;
    logic                        mac_valid;
    prod_t                       prod;
    logic                        mac_ready;
    logic                        sum_push;
    acc_t                        sum;
    logic [$clog2(`OUT_DEPTH):0] out_count;
    logic                        out_empty;
    acc_t                        out_data;
    logic                        out_pop;

    ////////////////////////////////////////////////////////////////////////////
    // Input side
    ////////////////////////////////////////////////////////////////////////////

    credit_fifo #(.T(pix_t), .DEPTH(`FEAT_DEPTH)) feat_buf_i (
        .i_clk    (i_clk),
        .i_rst_n  (i_rst_n),
        .i_push   (i_feat_valid),
        .i_data   (i_feat_data),
        .i_pop    (feat_pop),
        .o_data   (feat_data),
        .o_empty  (feat_empty),
        .o_count  (),
        .o_credit (o_feat_credit)
    );

    weight_loader weight_loader_i (
        .i_clk      (i_clk),
        .i_rst_n    (i_rst_n),
        .i_w_valid  (i_w_valid),
        .i_w_data   (i_w_data),
        .i_w_reload (i_w_reload),
        .o_w_credit (o_w_credit),
        .o_weights  (weights),
        .o_loaded   (loaded)
    );

    ////////////////////////////////////////////////////////////////////////////
    // Datapath
    ////////////////////////////////////////////////////////////////////////////

    column_mac column_mac_i (
        .i_clk     (i_clk),
        .i_rst_n   (i_rst_n),
        .i_valid   (feat_pop),
        .i_pix     (feat_data),
        .i_weights (weights),
        .o_valid   (mac_valid),
        .o_prod    (prod)
    );

    overlap_add overlap_add_i (
        .i_clk   (i_clk),
        .i_rst_n (i_rst_n),
        .i_valid (mac_valid),
        .i_prod  (prod),
        .o_ready (mac_ready),
        .o_push  (sum_push),
        .o_sum   (sum)
    );

    ////////////////////////////////////////////////////////////////////////////
    // Output side
    ////////////////////////////////////////////////////////////////////////////

    credit_fifo #(.T(acc_t), .DEPTH(`OUT_DEPTH)) out_buf_i (
        .i_clk    (i_clk),
        .i_rst_n  (i_rst_n),
        .i_push   (sum_push),
        .i_data   (sum),
        .i_pop    (out_pop),
        .o_data   (out_data),
        .o_empty  (out_empty),
        .o_count  (out_count),
        .o_credit ()
    );

    deconv_ctrl deconv_ctrl_i (
        .i_clk        (i_clk),
        .i_rst_n      (i_rst_n),
        .i_loaded     (loaded),
        .i_feat_empty (feat_empty),
        .i_mac_ready  (mac_ready),
        .i_out_count  (out_count),
        .i_out_empty  (out_empty),
        .i_out_data   (out_data),
        .i_out_credit (i_out_credit),
        .o_feat_pop   (feat_pop),
        .o_out_pop    (out_pop),
        .o_out_valid  (o_out_valid),
        .o_out_data   (o_out_data)
    );

endmodule

/* sim/tb_deconv_top.sv */
`timescale 1ns/1ps

`include "deconv_defs.svh"

module tb_deconv_top
    import deconv_pkg::*;
();

    localparam int          TIMEOUT   = 2000;
    localparam int          RAND_ROWS = 20;
    localparam logic [31:0] SEED      = 32'd75643;

    logic i_clk;
    logic i_rst_n;
    logic i_feat_valid;
    pix_t i_feat_data;
    logic o_feat_credit;
    logic i_w_valid;
    pix_t i_w_data;
    logic i_w_reload;
    logic o_w_credit;
    logic o_out_valid;
    acc_t o_out_data;
    logic i_out_credit;

    pix_t        cur_w [`KERNEL_SIZE];
    pix_t        row_buf [`ROW_LEN];
    logic [31:0] exp_q [$];
    logic [31:0] main_state;
    logic [31:0] credit_state;
    int          feat_credits;
    int          w_credits;
    int          feats_sent;
    int          feat_returned;
    int          w_returned;
    int          out_rcvd;
    int          credits_granted;
    int          rows_sent;
    int          checks;
    int          errors;

    deconv_top dut_i (
        .i_clk         (i_clk),
        .i_rst_n       (i_rst_n),
        .i_feat_valid  (i_feat_valid),
        .i_feat_data   (i_feat_data),
        .o_feat_credit (o_feat_credit),
        .i_w_valid     (i_w_valid),
        .i_w_data      (i_w_data),
        .i_w_reload    (i_w_reload),
        .o_w_credit    (o_w_credit),
        .o_out_valid   (o_out_valid),
        .o_out_data    (o_out_data),
        .i_out_credit  (i_out_credit)
    );

    always #5 i_clk = ~i_clk;

    function automatic logic [31:0] lcg_step(input logic [31:0] s);
        return s * 32'd1103515245 + 32'd12345;
    endfunction

    ////////////////////////////////////////////////////////////////////////////
    // Monitor and output credit return
    ////////////////////////////////////////////////////////////////////////////

    task automatic check_output;
        logic [31:0] exp;
        out_rcvd++;
        checks++;
        assert (out_rcvd <= credits_granted + `OUT_CREDITS)
        else
        begin
            $display("FAILED: o_out_valid count %h exceeds credit limit %h",
                     out_rcvd, credits_granted + `OUT_CREDITS);
            errors++;
        end
        checks++;
        assert (exp_q.size() != 0)
        else
        begin
            $display("Output arrived while no expected value was queued");
            errors++;
        end
        if (exp_q.size() != 0)
        begin
            exp = exp_q.pop_front();
            checks++;
            assert (o_out_data === exp)
            else
            begin
                $display("FAILED: o_out_data expected %h got %h", exp, o_out_data);
                errors++;
            end
        end
    endtask

    // Outputs sampled mid-cycle
    always @(negedge i_clk)
    begin
        if (i_rst_n)
        begin
            if (o_feat_credit)
            begin
                feat_credits++;
                feat_returned++;
            end
            if (o_w_credit)
            begin
                w_credits++;
                w_returned++;
            end
            if (o_out_valid)
            begin
                check_output();
            end
        end
    end

    // Consumer hands back credits with random gaps
    always @(posedge i_clk)
    begin
        if (!i_rst_n)
        begin
            i_out_credit <= 1'b0;
        end
        else
        begin
            credit_state = lcg_step(credit_state);
            if (out_rcvd > credits_granted && credit_state[31:30] == 2'b00)
            begin
                i_out_credit <= 1'b1;
                credits_granted++;
            end
            else
            begin
                i_out_credit <= 1'b0;
            end
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Stimulus tasks
    ////////////////////////////////////////////////////////////////////////////

    task automatic send_weight(input pix_t w);
        int t;
        t = 0;
        while (w_credits == 0 && t < TIMEOUT)
        begin
            @(posedge i_clk);
            t++;
        end
        if (w_credits == 0)
        begin
            $display("Timeout waiting for a weight credit");
            errors++;
        end
        else
        begin
            @(posedge i_clk);
            i_w_valid <= 1'b1;
            i_w_data  <= w;
            w_credits--;
            @(posedge i_clk);
            i_w_valid <= 1'b0;
        end
    endtask

    task automatic load_kernel;
        for (int k = 0; k < `KERNEL_SIZE; k++)
        begin
            send_weight(cur_w[k]);
        end
    endtask

    task automatic reload_kernel;
        int t;
        int snap;
        @(posedge i_clk);
        i_w_reload <= 1'b1;
        snap = w_returned;
        @(posedge i_clk);
        i_w_reload <= 1'b0;
        t = 0;
        while (w_credits < `KERNEL_SIZE && t < TIMEOUT)
        begin
            @(posedge i_clk);
            t++;
        end
        if (w_credits < `KERNEL_SIZE)
        begin
            $display("Timeout waiting for weight credits after reload");
            errors++;
        end
        repeat (`KERNEL_SIZE + 2) @(posedge i_clk);
        checks++;
        assert (w_returned - snap == `KERNEL_SIZE)
        else
        begin
            $display("FAILED: o_w_credit count expected %h got %h",
                     `KERNEL_SIZE, w_returned - snap);
            errors++;
        end
    endtask

    task automatic send_pixels;
        int t;
        for (int j = 0; j < `ROW_LEN; j++)
        begin
            t = 0;
            while (feat_credits == 0 && t < TIMEOUT)
            begin
                @(posedge i_clk);
                t++;
            end
            if (feat_credits == 0)
            begin
                $display("Timeout waiting for a feature credit");
                errors++;
            end
            else
            begin
                @(posedge i_clk);
                i_feat_valid <= 1'b1;
                i_feat_data  <= row_buf[j];
                feat_credits--;
                feats_sent++;
                @(posedge i_clk);
                i_feat_valid <= 1'b0;
                main_state = lcg_step(main_state);
                repeat (main_state[31:30]) @(posedge i_clk);
            end
        end
        rows_sent++;
    endtask

    // Output p collects x[j]*w[k] for every j*STRIDE+k == p
    task automatic push_model_row;
        logic signed [31:0] acc [`OUT_LEN];
        logic signed [31:0] xs;
        logic signed [31:0] ws;
        for (int p = 0; p < `OUT_LEN; p++)
        begin
            acc[p] = '0;
        end
        for (int j = 0; j < `ROW_LEN; j++)
        begin
            for (int k = 0; k < `KERNEL_SIZE; k++)
            begin
                xs = row_buf[j];
                ws = cur_w[k];
                acc[j * `STRIDE + k] = acc[j * `STRIDE + k] + xs * ws;
            end
        end
        for (int p = 0; p < `OUT_LEN; p++)
        begin
            exp_q.push_back(acc[p]);
        end
    endtask

    task automatic wait_drain;
        int t;
        t = 0;
        while (exp_q.size() != 0 && t < TIMEOUT)
        begin
            @(posedge i_clk);
            t++;
        end
        if (exp_q.size() != 0)
        begin
            $display("Timeout waiting for %0d outstanding outputs", exp_q.size());
            errors++;
        end
        repeat (4) @(posedge i_clk);
    endtask

    task automatic check_quiet_credits;
        checks++;
        assert (feat_returned == feats_sent && feat_credits == `FEAT_DEPTH)
        else
        begin
            $display("FAILED: o_feat_credit total expected %h got %h",
                     feats_sent, feat_returned);
            errors++;
        end
    endtask

    task automatic check_idle_outputs;
        repeat (8)
        begin
            @(negedge i_clk);
            checks++;
            assert (!o_out_valid && !o_feat_credit && !o_w_credit)
            else
            begin
                $display("FAILED: o_out_valid o_feat_credit o_w_credit expected 0 got %h %h %h",
                         o_out_valid, o_feat_credit, o_w_credit);
                errors++;
            end
        end
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // Test sequence
    ////////////////////////////////////////////////////////////////////////////

    initial
    begin
        i_clk           = 1'b0;
        i_rst_n         = 1'b0;
        i_feat_valid    = 1'b0;
        i_feat_data     = '0;
        i_w_valid       = 1'b0;
        i_w_data        = '0;
        i_w_reload      = 1'b0;
        i_out_credit    = 1'b0;
        main_state      = SEED;
        credit_state    = ~SEED;
        feat_credits    = `FEAT_DEPTH;
        w_credits       = `KERNEL_SIZE;
        feats_sent      = 0;
        feat_returned   = 0;
        w_returned      = 0;
        out_rcvd        = 0;
        credits_granted = 0;
        rows_sent       = 0;
        checks          = 0;
        errors          = 0;

        repeat (10) @(posedge i_clk);
        i_rst_n <= 1'b1;
        check_idle_outputs();

        // Known kernel and flat row
        cur_w[0] = 16'sd1;
        cur_w[1] = 16'sd2;
        cur_w[2] = 16'sd3;
        load_kernel();
        for (int j = 0; j < `ROW_LEN; j++)
        begin
            row_buf[j] = 16'sd1;
        end
        exp_q.push_back(32'd1);
        exp_q.push_back(32'd3);
        exp_q.push_back(32'd6);
        exp_q.push_back(32'd6);
        exp_q.push_back(32'd5);
        exp_q.push_back(32'd3);
        send_pixels();
        wait_drain();
        check_quiet_credits();

        // Random rows with a new kernel every ten rows
        for (int r = 0; r < RAND_ROWS; r++)
        begin
            if (r % 10 == 0)
            begin
                wait_drain();
                check_quiet_credits();
                reload_kernel();
                for (int k = 0; k < `KERNEL_SIZE; k++)
                begin
                    main_state = lcg_step(main_state);
                    cur_w[k]   = main_state[31:16];
                end
                load_kernel();
            end
            for (int j = 0; j < `ROW_LEN; j++)
            begin
                main_state = lcg_step(main_state);
                row_buf[j] = main_state[31:16];
            end
            push_model_row();
            send_pixels();
        end
        wait_drain();
        check_quiet_credits();

        checks++;
        assert (out_rcvd == rows_sent * `OUT_LEN)
        else
        begin
            $display("FAILED: o_out_valid count expected %h got %h",
                     rows_sent * `OUT_LEN, out_rcvd);
            errors++;
        end

        $display("Checks: %0d, errors: %0d, outputs: %0d", checks, errors, out_rcvd);
        if (errors == 0)
        begin
            $display("ALL TESTS PASSED");
        end
        else
        begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

endmodule

/* src.f */
+incdir+logic
logic/deconv_pkg.sv
logic/credit_fifo.sv
logic/weight_loader.sv
logic/column_mac.sv
logic/overlap_add.sv
logic/deconv_ctrl.sv
logic/deconv_top.sv
sim/tb_deconv_top.sv
